//--- bench/link_tb.sv
`include "link_settings.svh"

module link_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import link_pkg::*;

  localparam int   LANES    = `LINK_LANES;
  localparam int   PW       = `LINK_LANE_PAYLOAD_W;
  localparam int   DLY_X    = 4;
  localparam int   DLY_Y    = 3;
  localparam int   DLY_Z    = 2;
  localparam mrk_t USER_MRK = 2'b10;
  localparam logic USER_STB = 1'b1;

  // One stream beat with fields as driven upstream
  typedef struct packed {
    logic    valid;
    logic    crc_valid;
    logic    dvalid;
    protid_t protid;
    state_t  state;
    crc_t    crc;
    data_t   data;
  } stim_t;

  logic    clk_wr = 1'b0;
  logic    arst_n;
  logic    tx_online;
  logic    rx_online;
  delay_t  delay_x_value;
  delay_t  delay_y_value;
  delay_t  delay_z_value;
  mrk_t    tx_mrk_userbit;
  logic    tx_stb_userbit;
  lane_t   tx_phy0;
  lane_t   tx_phy1;
  lane_t   tx_phy2;
  lane_t   tx_phy3;
  lane_t   rx_phy0;
  lane_t   rx_phy1;
  lane_t   rx_phy2;
  lane_t   rx_phy3;
  state_t  ustrm_state;
  protid_t ustrm_protid;
  data_t   ustrm_data;
  logic    ustrm_dvalid;
  crc_t    ustrm_crc;
  logic    ustrm_crc_valid;
  logic    ustrm_valid;
  state_t  dstrm_state;
  protid_t dstrm_protid;
  data_t   dstrm_data;
  logic    dstrm_dvalid;
  crc_t    dstrm_crc;
  logic    dstrm_crc_valid;
  logic    dstrm_valid;

  // Open loopback switch takes rx lanes from rx_drv
  logic    loop_en;
  lane_t   rx_drv  [LANES];
  lane_t   tx_lane [LANES];

  stim_t   tbl      [$];
  string   tbl_name [$];
  int      err_cnt = 0;
  int      chk_cnt = 0;

  always #2 clk_wr = ~clk_wr;

  assign rx_phy0 = loop_en ? tx_phy0 : rx_drv[0];
  assign rx_phy1 = loop_en ? tx_phy1 : rx_drv[1];
  assign rx_phy2 = loop_en ? tx_phy2 : rx_drv[2];
  assign rx_phy3 = loop_en ? tx_phy3 : rx_drv[3];

  assign tx_lane[0] = tx_phy0;
  assign tx_lane[1] = tx_phy1;
  assign tx_lane[2] = tx_phy2;
  assign tx_lane[3] = tx_phy3;

  link_top DUT (.*);

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_flit(string name, flit_t exp, flit_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_lane(string name, lane_t exp, lane_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_crc(string name, crc_t exp, crc_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Data at bit 0, crc at 64, state at 80 and protid at 84
  // Qualifiers dvalid, crc_valid and valid sit at 86 to 88
  function automatic flit_t expect_fields(logic [`LINK_FLIT_W-1:0] raw);
    flit_t f;
    f = '0;
    // Empty flit stays all zero
    if (raw[88]) begin
      f.valid     = 1'b1;
      f.crc_valid = raw[87];
      f.dvalid    = raw[86];
      f.protid    = raw[85:84];
      f.state     = raw[83:80];
      if (raw[86]) f.data = raw[63:0];
      if (raw[87]) f.crc = raw[79:64];
    end
    return f;
  endfunction

  function automatic flit_t stim_flit(stim_t s);
    logic [`LINK_FLIT_W-1:0] raw;
    raw = {7'b0, s.valid, s.crc_valid, s.dvalid, s.protid, s.state, s.crc, s.data};
    return expect_fields(raw);
  endfunction

  // Downstream ports gathered back into flit form
  function automatic flit_t dstrm_flit();
    flit_t f;
    f           = '0;
    f.data      = dstrm_data;
    f.crc       = dstrm_crc;
    f.state     = dstrm_state;
    f.protid    = dstrm_protid;
    f.dvalid    = dstrm_dvalid;
    f.crc_valid = dstrm_crc_valid;
    f.valid     = dstrm_valid;
    return f;
  endfunction

  // Lane k holds flit bits from 24k with user bits on top
  task automatic check_tx(string name, flit_t f, bit on, bit user);
    lane_t                   exp;
    logic [`LINK_FLIT_W-1:0] bits;
    bits = f;
    for (int k = 0; k < LANES; k++) begin
      exp.payload = on ? bits[k*PW +: PW] : '0;
      exp.stb     = user ? USER_STB : 1'b0;
      exp.mrk     = user ? USER_MRK : '0;
      check_lane($sformatf("%s lane%0d", name, k), exp, tx_lane[k]);
    end
  endtask

  task automatic drive_stim(stim_t s);
    ustrm_state     = s.state;
    ustrm_protid    = s.protid;
    ustrm_data      = s.data;
    ustrm_dvalid    = s.dvalid;
    ustrm_crc       = s.crc;
    ustrm_crc_valid = s.crc_valid;
    ustrm_valid     = s.valid;
  endtask

  task automatic add_entry(string name, state_t st, protid_t pid, data_t d, logic dv,
                           crc_t c, logic cv, logic v);
    stim_t s;
    s = '{valid: v, crc_valid: cv, dvalid: dv, protid: pid, state: st, crc: c, data: d};
    tbl.push_back(s);
    tbl_name.push_back(name);
  endtask

  task automatic build_table();
    add_entry("full", 4'h3, 2'd1, 64'h0123_4567_89ab_cdef, 1'b1, 16'hbeef, 1'b1, 1'b1);
    add_entry("no_dvalid", 4'h5, 2'd2, 64'hdead_beef_cafe_f00d, 1'b0, 16'h1234, 1'b1, 1'b1);
    add_entry("no_crc", 4'ha, 2'd3, 64'hffff_0000_ffff_0000, 1'b1, 16'h5a5a, 1'b0, 1'b1);
    add_entry("bare", 4'hf, 2'd0, 64'h1111_2222_3333_4444, 1'b0, 16'hffff, 1'b0, 1'b1);
    // Junk in every field but no valid
    add_entry("empty", 4'h7, 2'd3, '1, 1'b1, '1, 1'b1, 1'b0);
    add_entry("all_ones", 4'hf, 2'd3, '1, 1'b1, '1, 1'b1, 1'b1);
    for (int i = 0; i < 3; i++) begin
      add_entry($sformatf("rand%0d", i), state_t'($urandom), protid_t'($urandom),
                {$urandom, $urandom}, 1'($urandom), crc_t'($urandom), 1'($urandom), 1'b1);
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin : watchdog
    int limit;
    #1;
    limit = tbl.size() * 10 + ((DLY_Y + DLY_Z > DLY_X) ? DLY_Y + DLY_Z : DLY_X) + 200;
    repeat (limit) @(posedge clk_wr);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    int                      n;
    stim_t                   idle;
    flit_t                   exp;
    flit_t                   exp_q [$];
    logic [`LINK_FLIT_W-1:0] raw;
    void'($urandom(32'h51eb));
    idle = '0;
    arst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_x_value = delay_t'(DLY_X);
    delay_y_value = delay_t'(DLY_Y);
    delay_z_value = delay_t'(DLY_Z);
    tx_mrk_userbit = USER_MRK;
    tx_stb_userbit = USER_STB;
    loop_en = 1'b1;
    for (int k = 0; k < LANES; k++) rx_drv[k] = '0;
    drive_stim(idle);
    build_table();

    repeat (5) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n = 1'b1;
    // Everything idle out of reset
    check_tx("reset", '0, 1'b0, 1'b0);
    check_flit("reset dstrm", '0, dstrm_flit());

    // Tx online brings payload after y+z+1 edges and user bits after 1
    drive_stim(tbl[0]);
    tx_online = 1'b1;
    for (int i = 0; i <= DLY_Y + DLY_Z + 3; i++) begin
      @(negedge clk_wr);
      check_tx($sformatf("tx_online c%0d", i), stim_flit(tbl[0]), i >= DLY_Y + DLY_Z + 1,
               i >= 1);
    end

    // Looped flits reach dstrm x+1 edges after rx online
    rx_online = 1'b1;
    for (int i = 0; i <= DLY_X + 3; i++) begin
      @(negedge clk_wr);
      exp = (i >= DLY_X + 1) ? stim_flit(tbl[0]) : '0;
      check_bit($sformatf("rx_online valid c%0d", i), exp.valid, dstrm_valid);
      check_data($sformatf("rx_online data c%0d", i), exp.data, dstrm_data);
      check_crc($sformatf("rx_online crc c%0d", i), exp.crc, dstrm_crc);
    end

    // Loopback table with lanes one cycle and dstrm three cycles behind
    n = tbl.size();
    for (int c = 0; c < n + 3; c++) begin
      @(negedge clk_wr);
      if (c >= 1 && c <= n) check_tx(tbl_name[c-1], stim_flit(tbl[c-1]), 1'b1, 1'b1);
      if (c >= 3) check_flit(tbl_name[c-3], stim_flit(tbl[c-3]), dstrm_flit());
      drive_stim(c < n ? tbl[c] : idle);
    end

    // Random lanes with the loop open reach dstrm two cycles later
    loop_en = 1'b0;
    for (int c = 0; c < 10; c++) begin
      @(negedge clk_wr);
      if (c >= 2) check_flit($sformatf("lanes%0d", c - 2), exp_q.pop_front(), dstrm_flit());
      if (c < 8) begin
        for (int k = 0; k < LANES; k++) begin
          rx_drv[k] = lane_t'($urandom);
          raw[k*PW +: PW] = rx_drv[k].payload;
        end
        exp_q.push_back(expect_fields(raw));
      end
    end

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- logic/link_auto_sync.sv
`include "link_settings.svh"

module link_auto_sync #(
  // Keep marker bits on after tx_online_dly rises
  parameter bit PERSISTENT_MARKER = 1'b1,
  // Keep strobe bit on after tx_online_dly rises
  parameter bit PERSISTENT_STROBE = 1'b1
) (
  input  logic             clk_wr,
  input  logic             arst_n,

  // Raw online indications
  input  logic             tx_online,
  input  logic             rx_online,

  // Startup delays in clocks
  input  link_pkg::delay_t delay_x_value,
  input  link_pkg::delay_t delay_y_value,
  input  link_pkg::delay_t delay_z_value,

  // User bits for the lanes
  input  link_pkg::mrk_t   tx_mrk_userbit,
  input  logic             tx_stb_userbit,

  // Delayed online toward the lane mapper
  output logic             tx_online_dly,
  output logic             rx_online_dly,

  // Gated user bits toward the lane mapper
  output link_pkg::mrk_t   tx_auto_mrk,
  output logic             tx_auto_stb
);

  // One extra bit so y plus z never wraps
  localparam int CNT_W = `LINK_DELAY_W + 1;

  // Channel slots
  localparam int TX_CH = 0;
  localparam int RX_CH = 1;
  localparam int N_CH  = 2;

  logic [N_CH-1:0]  online_in;
  logic [CNT_W-1:0] target [N_CH];
  logic [CNT_W-1:0] cnt_q  [N_CH];
  logic             dly_q  [N_CH];

  logic             mrk_en;
  logic             stb_en;

  ////////////////////
  // Online delay
  ////////////////////

  assign online_in[TX_CH] = tx_online;
  assign online_in[RX_CH] = rx_online;

  // Tx waits for both y and z
  assign target[TX_CH] = CNT_W'(delay_y_value) + CNT_W'(delay_z_value);
  // Rx waits for word alignment only
  assign target[RX_CH] = CNT_W'(delay_x_value);

  for (genvar i = 0; i < N_CH; i++) begin : g_dly
    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        cnt_q[i] <= '0;
        dly_q[i] <= 1'b0;
      end else if (!online_in[i]) begin
        // Drop straight away, start over next time
        cnt_q[i] <= '0;
        dly_q[i] <= 1'b0;
      end else if (cnt_q[i] >= target[i]) begin
        // Saturated, hold count
        dly_q[i] <= 1'b1;
      end else begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign tx_online_dly = dly_q[TX_CH];
  assign rx_online_dly = dly_q[RX_CH];

  ////////////////////
  // Marker and strobe
  ////////////////////

  // Persistent bits follow tx_online
  // Others stop once the delayed online is up
  assign mrk_en = tx_online & (PERSISTENT_MARKER | ~dly_q[TX_CH]);
  assign stb_en = tx_online & (PERSISTENT_STROBE | ~dly_q[TX_CH]);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_auto_mrk <= '0;
      tx_auto_stb <= 1'b0;
    end else begin
      tx_auto_mrk <= mrk_en ? tx_mrk_userbit : '0;
      tx_auto_stb <= stb_en & tx_stb_userbit;
    end
  end

endmodule

//--- logic/link_flit_pack.sv
module link_flit_pack (
  input  logic              clk_wr,
  input  logic              arst_n,

  // Upstream stream from the protocol stack
  input  link_pkg::state_t  ustrm_state,
  input  link_pkg::protid_t ustrm_protid,
  input  link_pkg::data_t   ustrm_data,
  input  logic              ustrm_dvalid,
  input  link_pkg::crc_t    ustrm_crc,
  input  logic              ustrm_crc_valid,
  input  logic              ustrm_valid,

  // Flit toward the lane mapper
  output link_pkg::flit_t   tx_flit,

  // Flit from the lane mapper
  input  link_pkg::flit_t   rx_flit,

  // Downstream stream to the protocol stack
  output link_pkg::state_t  dstrm_state,
  output link_pkg::protid_t dstrm_protid,
  output link_pkg::data_t   dstrm_data,
  output logic              dstrm_dvalid,
  output link_pkg::crc_t    dstrm_crc,
  output logic              dstrm_crc_valid,
  output logic              dstrm_valid
);

  import link_pkg::*;

  flit_t tx_raw;
  flit_t rx_clean;

  // Zero every field whose qualifier is low
  function automatic flit_t qualify(flit_t f);
    flit_t q;
    q = f;
    if (!f.dvalid) q.data = '0;
    if (!f.crc_valid) q.crc = '0;
    // Empty flit carries nothing at all
    if (!f.valid) q = '0;
    return q;
  endfunction

  ////////////////////
  // Transmit packing
  ////////////////////

  always_comb begin
    // Pad bits stay zero
    tx_raw           = '0;
    tx_raw.data      = ustrm_data;
    tx_raw.crc       = ustrm_crc;
    tx_raw.state     = ustrm_state;
    tx_raw.protid    = ustrm_protid;
    tx_raw.dvalid    = ustrm_dvalid;
    tx_raw.crc_valid = ustrm_crc_valid;
    tx_raw.valid     = ustrm_valid;
  end

  // No register here, lane mapper adds the cycle
  assign tx_flit = qualify(tx_raw);

  ////////////////////
  // Receive unpacking
  ////////////////////

  // Lane source is not trusted to clear fields
  assign rx_clean = qualify(rx_flit);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= 1'b0;
      dstrm_valid     <= 1'b0;
    end else begin
      dstrm_state     <= rx_clean.state;
      dstrm_protid    <= rx_clean.protid;
      dstrm_data      <= rx_clean.data;
      dstrm_dvalid    <= rx_clean.dvalid;
      dstrm_crc       <= rx_clean.crc;
      dstrm_crc_valid <= rx_clean.crc_valid;
      dstrm_valid     <= rx_clean.valid;
    end
  end

endmodule

//--- logic/link_lane_map.sv
`include "link_settings.svh"

module link_lane_map (
  input  logic            clk_wr,
  input  logic            arst_n,

  // Transmit flit and startup controls
  input  link_pkg::flit_t tx_flit,
  input  logic            tx_online_dly,
  input  link_pkg::mrk_t  tx_auto_mrk,
  input  logic            tx_auto_stb,

  // PHY transmit lanes
  output link_pkg::lane_t tx_phy0,
  output link_pkg::lane_t tx_phy1,
  output link_pkg::lane_t tx_phy2,
  output link_pkg::lane_t tx_phy3,

  // PHY receive lanes
  input  link_pkg::lane_t rx_phy0,
  input  link_pkg::lane_t rx_phy1,
  input  link_pkg::lane_t rx_phy2,
  input  link_pkg::lane_t rx_phy3,
  input  logic            rx_online_dly,

  // Reassembled receive flit
  output link_pkg::flit_t rx_flit
);

  import link_pkg::*;

  localparam int LANE_PW = `LINK_LANE_PAYLOAD_W;

  // Flit as a flat vector for slicing
  logic [`LINK_FLIT_W-1:0] tx_bits;
  logic [`LINK_FLIT_W-1:0] rx_bits;

  payload_t tx_payload   [`LINK_LANES];
  lane_t    tx_lane_q    [`LINK_LANES];
  lane_t    rx_lane      [`LINK_LANES];
  payload_t rx_payload_q [`LINK_LANES];

  ////////////////////
  // Transmit striping
  ////////////////////

  assign tx_bits = tx_flit;

  // Lane k takes flit bits from 24k upward
  always_comb begin
    for (int k = 0; k < `LINK_LANES; k++) begin
      // Idle lanes until the link is up
      tx_payload[k] = tx_online_dly ? tx_bits[k*LANE_PW +: LANE_PW] : '0;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < `LINK_LANES; k++) begin
        tx_lane_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `LINK_LANES; k++) begin
        tx_lane_q[k].payload <= tx_payload[k];
        // Same strobe and marker on every lane
        tx_lane_q[k].stb     <= tx_auto_stb;
        tx_lane_q[k].mrk     <= tx_auto_mrk;
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  ////////////////////
  // Receive reassembly
  ////////////////////

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Strobe and marker are dropped here
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < `LINK_LANES; k++) begin
        rx_payload_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `LINK_LANES; k++) begin
        rx_payload_q[k] <= rx_lane[k].payload;
      end
    end
  end

  // Join lane payloads back into one flit
  always_comb begin
    for (int k = 0; k < `LINK_LANES; k++) begin
      rx_bits[k*LANE_PW +: LANE_PW] = rx_payload_q[k];
    end
  end

  always_comb begin
    rx_flit = flit_t'(rx_bits);
    // Nothing is valid before rx word alignment
    if (!rx_online_dly) begin
      rx_flit.valid     = 1'b0;
      rx_flit.dvalid    = 1'b0;
      rx_flit.crc_valid = 1'b0;
    end
  end

endmodule

//--- logic/link_pkg.sv
`include "link_settings.svh"

package link_pkg;

  ////////////////////
  // Stream fields
  ////////////////////

  typedef logic [`LINK_DATA_W-1:0] data_t;
  typedef logic [15:0]             crc_t;
  typedef logic [3:0]              state_t;
  typedef logic [1:0]              protid_t;

  // Link startup fields
  typedef logic [`LINK_MRK_W-1:0]   mrk_t;
  typedef logic [`LINK_DELAY_W-1:0] delay_t;

  // Flit bits carried by one lane
  typedef logic [`LINK_LANE_PAYLOAD_W-1:0] payload_t;

  // Unused flit bits above the qualifiers
  localparam int FLIT_PAD_W = `LINK_FLIT_W - $bits(data_t) - $bits(crc_t)
                              - $bits(state_t) - $bits(protid_t) - 3;

  // Flit layout, data at the LSB
  typedef struct packed {
    logic [FLIT_PAD_W-1:0] pad;
    logic                  valid;
    logic                  crc_valid;
    logic                  dvalid;
    protid_t               protid;
    state_t                state;
    crc_t                  crc;
    data_t                 data;
  } flit_t;

  // One PHY lane, payload at the LSB
  typedef struct packed {
    mrk_t     mrk;
    logic     stb;
    payload_t payload;
  } lane_t;

endpackage

//--- logic/link_settings.svh
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

////////////////////
// Stream widths
////////////////////

// Upstream and downstream data bus
`define LINK_DATA_W 64

////////////////////
// PHY lanes
////////////////////

// Parallel lanes toward the PHY
`define LINK_LANES 4
// Flit bits carried by one lane
`define LINK_LANE_PAYLOAD_W 24
// Marker user bits per lane
`define LINK_MRK_W 2
// Online delay values
`define LINK_DELAY_W 16

// Whole flit striped across all lanes
`define LINK_FLIT_W (`LINK_LANES * `LINK_LANE_PAYLOAD_W)
// Payload plus strobe plus marker
`define LINK_LANE_W (`LINK_LANE_PAYLOAD_W + 1 + `LINK_MRK_W)

`endif

//--- logic/link_top.sv
module link_top (
  input  logic              clk_wr,
  input  logic              arst_n,

  // Control
  input  logic              tx_online,
  input  logic              rx_online,

  // Startup configuration
  input  link_pkg::delay_t  delay_x_value,
  input  link_pkg::delay_t  delay_y_value,
  input  link_pkg::delay_t  delay_z_value,
  input  link_pkg::mrk_t    tx_mrk_userbit,
  input  logic              tx_stb_userbit,

  // PHY interconnect
  output link_pkg::lane_t   tx_phy0,
  output link_pkg::lane_t   tx_phy1,
  output link_pkg::lane_t   tx_phy2,
  output link_pkg::lane_t   tx_phy3,
  input  link_pkg::lane_t   rx_phy0,
  input  link_pkg::lane_t   rx_phy1,
  input  link_pkg::lane_t   rx_phy2,
  input  link_pkg::lane_t   rx_phy3,

  // Upstream channel
  input  link_pkg::state_t  ustrm_state,
  input  link_pkg::protid_t ustrm_protid,
  input  link_pkg::data_t   ustrm_data,
  input  logic              ustrm_dvalid,
  input  link_pkg::crc_t    ustrm_crc,
  input  logic              ustrm_crc_valid,
  input  logic              ustrm_valid,

  // Downstream channel
  output link_pkg::state_t  dstrm_state,
  output link_pkg::protid_t dstrm_protid,
  output link_pkg::data_t   dstrm_data,
  output logic              dstrm_dvalid,
  output link_pkg::crc_t    dstrm_crc,
  output logic              dstrm_crc_valid,
  output logic              dstrm_valid
);

  import link_pkg::*;

  ////////////////////
  // Interconnect
  ////////////////////

  flit_t tx_flit;
  flit_t rx_flit;
  logic  tx_online_dly;
  logic  rx_online_dly;
  mrk_t  tx_auto_mrk;
  logic  tx_auto_stb;

  // Startup sequencing, both user bits kept on
  link_auto_sync #(
    .PERSISTENT_MARKER (1'b1),
    .PERSISTENT_STROBE (1'b1)
  ) link_auto_sync_i (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_online_dly  (tx_online_dly),
    .rx_online_dly  (rx_online_dly),
    .tx_auto_mrk    (tx_auto_mrk),
    .tx_auto_stb    (tx_auto_stb)
  );

  // Stream fields to and from flits
  // No FIFO or credits, one flit per clock
  link_flit_pack link_flit_pack_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  // Flits to and from PHY lanes
  link_lane_map link_lane_map_i (
    .clk_wr        (clk_wr),
    .arst_n        (arst_n),
    .tx_flit       (tx_flit),
    .tx_online_dly (tx_online_dly),
    .tx_auto_mrk   (tx_auto_mrk),
    .tx_auto_stb   (tx_auto_stb),
    .tx_phy0       (tx_phy0),
    .tx_phy1       (tx_phy1),
    .tx_phy2       (tx_phy2),
    .tx_phy3       (tx_phy3),
    .rx_phy0       (rx_phy0),
    .rx_phy1       (rx_phy1),
    .rx_phy2       (rx_phy2),
    .rx_phy3       (rx_phy3),
    .rx_online_dly (rx_online_dly),
    .rx_flit       (rx_flit)
  );

endmodule

//--- project.f
+incdir+logic
logic/link_pkg.sv
logic/link_auto_sync.sv
logic/link_flit_pack.sv
logic/link_lane_map.sv
logic/link_top.sv
bench/link_tb.sv
